// File: logic/alloc_settings.svh
`ifndef ALLOC_SETTINGS_SVH
`define ALLOC_SETTINGS_SVH

// router geometry
`define ALLOC_P 5
`define ALLOC_V 2

// a port never routes back to itself
`define ALLOC_P_1 (`ALLOC_P - 1)

// every vc in the router, port by port
`define ALLOC_PV (`ALLOC_P * `ALLOC_V)

`endif

// File: logic/alloc_pkg.sv
`include "alloc_settings.svh"

package alloc_pkg;

    // one bit per vc of a single port
    typedef logic [`ALLOC_V-1:0] vc_mask_t;

    // one-hot destination, own port skipped
    typedef logic [`ALLOC_P_1-1:0] port_sel_t;

    // one bit per ivc (or ovc), ordered port by port
    typedef logic [`ALLOC_PV-1:0] ivc_vec_t;

    typedef logic [`ALLOC_P-1:0] port_vec_t;

    // destination of each ivc
    typedef port_sel_t [`ALLOC_PV-1:0] dest_array_t;

    // acceptable ovcs per ivc, also used for granted ovcs
    typedef vc_mask_t [`ALLOC_PV-1:0] vc_req_array_t;

    // granted output per input port
    typedef port_sel_t [`ALLOC_P-1:0] port_grant_array_t;

endpackage

// File: logic/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] request,
    output logic [WIDTH-1:0] grant,
    output logic             any_grant
);

    // bits at or above the pointer, all ones means index 0 first
    logic [WIDTH-1:0] prio_mask;
    logic [WIDTH-1:0] masked_req;
    logic [WIDTH-1:0] pick;
    logic [WIDTH-1:0] grant_shift;

    assign masked_req  = request & prio_mask;
    assign pick        = (|masked_req) ? masked_req : request; // wrap around
    assign grant       = pick & (~pick + 1'b1);                 // lowest set bit
    assign any_grant   = |request;
    assign grant_shift = grant << 1;

    always_ff @(posedge clk) begin
        if (rst) begin
            prio_mask <= '1;
        end else if (any_grant) begin
            // winner drops to lowest priority, top winner wraps to all zeros
            prio_mask <= ~(grant_shift - 1'b1);
        end
    end

endmodule

// File: logic/vc_allocator.sv
`timescale 1ns/1ps
`include "alloc_settings.svh"

module vc_allocator
    import alloc_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  dest_array_t   dest_port,
    input  vc_req_array_t ovc_request,
    output vc_req_array_t granted_ovc,
    output ivc_vec_t      ovc_allocated,
    output ivc_vec_t      ivc_vc_granted
);

    localparam int V    = `ALLOC_V;
    localparam int P_1  = `ALLOC_P_1;
    localparam int PV   = `ALLOC_PV;
    localparam int VP_1 = V * P_1;

    vc_mask_t first_grant [PV];       // ovc picked by each ivc
    vc_mask_t back_grant  [PV][P_1];  // second stage result, per ivc and destination slot

    // stage one, each ivc picks one candidate ovc
    for (genvar i = 0; i < PV; i++) begin : g_first
        rr_arbiter #(
            .WIDTH (V)
        ) first_arb (
            .clk       (clk),
            .rst       (rst),
            .request   (ovc_request[i]),
            .grant     (first_grant[i]),
            .any_grant ()
        );
    end

    // stage two, each ovc picks among ivcs of the other ports
    for (genvar o = 0; o < PV; o++) begin : g_ovc
        localparam int OP = o / V;  // port owning this ovc
        localparam int OV = o % V;
        logic [VP_1-1:0] req2;
        logic [VP_1-1:0] gnt2;

        for (genvar j = 0; j < PV; j++) begin : g_ivc
            localparam int JP = j / V;
            if (JP != OP) begin : g_other
                localparam int SLOT = (JP < OP) ? j : j - V;    // own port's ivcs skipped
                localparam int SEL  = (OP < JP) ? OP : OP - 1;  // dest bit meaning port OP
                assign req2[SLOT] = first_grant[j][OV] & dest_port[j][SEL];
                assign back_grant[j][SEL][OV] = gnt2[SLOT];
            end
        end

        rr_arbiter #(
            .WIDTH (VP_1)
        ) second_arb (
            .clk       (clk),
            .rst       (rst),
            .request   (req2),
            .grant     (gnt2),
            .any_grant (ovc_allocated[o])
        );
    end

    // fold the per-port slots back into one ovc mask per ivc
    always_comb begin
        for (int i = 0; i < PV; i++) begin
            granted_ovc[i] = '0;
            for (int k = 0; k < P_1; k++) begin
                granted_ovc[i] = granted_ovc[i] | back_grant[i][k];
            end
            ivc_vc_granted[i] = |granted_ovc[i];
        end
    end

endmodule

// File: logic/sw_alloc_stage.sv
`timescale 1ns/1ps
`include "alloc_settings.svh"

module sw_alloc_stage
    import alloc_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  ivc_vec_t          ivc_request,
    input  dest_array_t       dest_port,
    input  ivc_vec_t          credit_ok,
    output ivc_vec_t          first_grant,
    output ivc_vec_t          ivc_granted,
    output port_grant_array_t granted_dest_port,
    output port_vec_t         inport_granted,
    output port_vec_t         outport_granted
);

    localparam int P   = `ALLOC_P;
    localparam int V   = `ALLOC_V;
    localparam int P_1 = `ALLOC_P_1;

    port_sel_t in_dest [P];  // destination of each input port's winner

    // input stage, one ivc with credit per port
    for (genvar p = 0; p < P; p++) begin : g_in_arb
        rr_arbiter #(
            .WIDTH (V)
        ) in_arb (
            .clk       (clk),
            .rst       (rst),
            .request   (ivc_request[p*V +: V] & credit_ok[p*V +: V]),
            .grant     (first_grant[p*V +: V]),
            .any_grant ()
        );
    end

    always_comb begin
        for (int p = 0; p < P; p++) begin
            in_dest[p] = '0;
            for (int v = 0; v < V; v++) begin
                if (first_grant[p*V + v]) in_dest[p] = in_dest[p] | dest_port[p*V + v];
            end
        end
    end

    // output stage, one input port per output
    for (genvar op = 0; op < P; op++) begin : g_out
        logic [P_1-1:0] req_o;
        logic [P_1-1:0] gnt_o;

        for (genvar ip = 0; ip < P; ip++) begin : g_in
            if (ip != op) begin : g_other
                localparam int SLOT = (ip < op) ? ip : ip - 1;
                localparam int SEL  = (op < ip) ? op : op - 1;
                assign req_o[SLOT] = in_dest[ip][SEL];
                assign granted_dest_port[ip][SEL] = gnt_o[SLOT];
            end
        end

        rr_arbiter #(
            .WIDTH (P_1)
        ) out_arb (
            .clk       (clk),
            .rst       (rst),
            .request   (req_o),
            .grant     (gnt_o),
            .any_grant (outport_granted[op])
        );
    end

    always_comb begin
        for (int p = 0; p < P; p++) begin
            inport_granted[p] = |granted_dest_port[p];
            ivc_granted[p*V +: V] = first_grant[p*V +: V] & {V{inport_granted[p]}};
        end
    end

endmodule

// File: logic/spec_sw_allocator.sv
`timescale 1ns/1ps
`include "alloc_settings.svh"

module spec_sw_allocator
    import alloc_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  ivc_vec_t          ivc_request,
    input  ivc_vec_t          ovc_is_assigned,
    input  ivc_vec_t          assigned_ovc_not_full,
    input  dest_array_t       dest_port,
    input  port_vec_t         valid_speculation,
    output ivc_vec_t          spec_first_grant,
    output ivc_vec_t          ivc_sw_granted,
    output port_grant_array_t granted_dest_port,
    output port_vec_t         any_sw_granted
);

    localparam int P   = `ALLOC_P;
    localparam int V   = `ALLOC_V;
    localparam int P_1 = `ALLOC_P_1;

    ivc_vec_t          nonspec_req;
    ivc_vec_t          spec_req;
    ivc_vec_t          nonspec_ivc_granted;
    ivc_vec_t          spec_ivc_granted;
    port_grant_array_t nonspec_dest;
    port_grant_array_t spec_dest;
    port_vec_t         nonspec_in;
    port_vec_t         nonspec_out;
    port_grant_array_t accepted_dest;  // speculative destinations that survive
    port_vec_t         spec_ok;

    assign nonspec_req = ivc_request & ovc_is_assigned;
    assign spec_req    = ivc_request & ~ovc_is_assigned;

    sw_alloc_stage nonspec_stage (
        .clk               (clk),
        .rst               (rst),
        .ivc_request       (nonspec_req),
        .dest_port         (dest_port),
        .credit_ok         (assigned_ovc_not_full),
        .first_grant       (),
        .ivc_granted       (nonspec_ivc_granted),
        .granted_dest_port (nonspec_dest),
        .inport_granted    (nonspec_in),
        .outport_granted   (nonspec_out)
    );

    sw_alloc_stage spec_stage (
        .clk               (clk),
        .rst               (rst),
        .ivc_request       (spec_req),
        .dest_port         (dest_port),
        .credit_ok         ('1),  // no ovc yet, nothing to check
        .first_grant       (spec_first_grant),
        .ivc_granted       (spec_ivc_granted),
        .granted_dest_port (spec_dest),
        .inport_granted    (),
        .outport_granted   ()
    );

    // non-speculative grants win both ports
    always_comb begin
        logic out_taken;
        for (int i = 0; i < P; i++) begin
            for (int k = 0; k < P_1; k++) begin
                out_taken = (k < i) ? nonspec_out[k] : nonspec_out[k + 1]; // slot k skips port i
                accepted_dest[i][k] = spec_dest[i][k] & ~out_taken & ~nonspec_in[i]
                                    & valid_speculation[i];
            end
            spec_ok[i] = |accepted_dest[i];
            ivc_sw_granted[i*V +: V] = nonspec_ivc_granted[i*V +: V]
                                     | (spec_ivc_granted[i*V +: V] & {V{spec_ok[i]}});
            granted_dest_port[i] = nonspec_dest[i] | accepted_dest[i];
        end
    end

    assign any_sw_granted = nonspec_in | spec_ok;

endmodule

// File: logic/baseline_allocator.sv
`timescale 1ns/1ps
`include "alloc_settings.svh"

module baseline_allocator
    import alloc_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  dest_array_t       dest_port,
    input  vc_req_array_t     ovc_request,
    input  ivc_vec_t          ivc_request,
    input  ivc_vec_t          ovc_is_assigned,
    input  ivc_vec_t          assigned_ovc_not_full,
    output vc_req_array_t     granted_ovc,
    output ivc_vec_t          ovc_allocated,
    output ivc_vec_t          ivc_vc_granted,
    output ivc_vec_t          ivc_sw_granted,
    output port_grant_array_t granted_dest_port,
    output port_vec_t         any_sw_granted
);

    localparam int P = `ALLOC_P;
    localparam int V = `ALLOC_V;

    ivc_vec_t  spec_first_grant;   // speculative input-stage winners
    port_vec_t valid_speculation;

    vc_allocator vc_alloc_i (
        .clk            (clk),
        .rst            (rst),
        .dest_port      (dest_port),
        .ovc_request    (ovc_request),
        .granted_ovc    (granted_ovc),
        .ovc_allocated  (ovc_allocated),
        .ivc_vc_granted (ivc_vc_granted)
    );

    spec_sw_allocator sw_alloc_i (
        .clk                   (clk),
        .rst                   (rst),
        .ivc_request           (ivc_request),
        .ovc_is_assigned       (ovc_is_assigned),
        .assigned_ovc_not_full (assigned_ovc_not_full),
        .dest_port             (dest_port),
        .valid_speculation     (valid_speculation),
        .spec_first_grant      (spec_first_grant),
        .ivc_sw_granted        (ivc_sw_granted),
        .granted_dest_port     (granted_dest_port),
        .any_sw_granted        (any_sw_granted)
    );

    // speculation only counts if the same ivc won an ovc this cycle
    always_comb begin
        for (int p = 0; p < P; p++) begin
            valid_speculation[p] = |(spec_first_grant[p*V +: V] & ivc_vc_granted[p*V +: V]);
        end
    end

endmodule

// File: dv/baseline_allocator_chk.sv
`timescale 1ns/1ps
`include "alloc_settings.svh"

module baseline_allocator_chk
    import alloc_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input dest_array_t       dest_port,
    input vc_req_array_t     granted_ovc,
    input ivc_vec_t          ivc_sw_granted,
    input port_grant_array_t granted_dest_port
);

    localparam int P   = `ALLOC_P;
    localparam int V   = `ALLOC_V;
    localparam int P_1 = `ALLOC_P_1;
    localparam int PV  = `ALLOC_PV;

    ivc_vec_t  ovc_seen;
    port_vec_t out_seen;
    logic      ovc_clash;
    logic      in_clash;
    logic      out_clash;

    always_comb begin
        int o;
        ovc_seen  = '0;
        out_seen  = '0;
        ovc_clash = 1'b0;
        in_clash  = 1'b0;
        out_clash = 1'b0;
        for (int i = 0; i < PV; i++) begin
            for (int k = 0; k < P_1; k++) begin
                for (int v = 0; v < V; v++) begin
                    o = ((k < i / V) ? k : k + 1) * V + v;  // ovc behind dest bit k
                    if (dest_port[i][k] && granted_ovc[i][v]) begin
                        ovc_clash   = ovc_clash | ovc_seen[o];
                        ovc_seen[o] = 1'b1;
                    end
                end
            end
        end
        for (int p = 0; p < P; p++) begin
            in_clash = in_clash | !$onehot0(ivc_sw_granted[p*V +: V])
                                | !$onehot0(granted_dest_port[p]);
            for (int k = 0; k < P_1; k++) begin
                if (granted_dest_port[p][k]) begin
                    out_clash = out_clash | out_seen[(k < p) ? k : k + 1];
                    out_seen[(k < p) ? k : k + 1] = 1'b1;
                end
            end
        end
    end

    a_ovc_once: assert property (@(posedge clk) disable iff (rst) !ovc_clash)
        else $error("an ovc was granted to two ivcs");

    a_inport_once: assert property (@(posedge clk) disable iff (rst) !in_clash)
        else $error("an input port holds more than one switch grant");

    a_outport_once: assert property (@(posedge clk) disable iff (rst) !out_clash)
        else $error("an output port was granted to two input ports");

endmodule

// the top sees both the vc and the switch grants
bind baseline_allocator baseline_allocator_chk chk_i (
    .clk               (clk),
    .rst               (rst),
    .dest_port         (dest_port),
    .granted_ovc       (granted_ovc),
    .ivc_sw_granted    (ivc_sw_granted),
    .granted_dest_port (granted_dest_port)
);

// File: dv/baseline_allocator_tb.sv
`timescale 1ns/1ps
`include "alloc_settings.svh"

module baseline_allocator_tb
    import alloc_pkg::*;
();

    localparam int P   = `ALLOC_P;
    localparam int V   = `ALLOC_V;
    localparam int P_1 = `ALLOC_P_1;
    localparam int PV  = `ALLOC_PV;
    localparam int RANDOM_CYCLES   = 3000;
    localparam int DIRECTED_CYCLES = 40;   // four resets plus the directed phases
    localparam int TIMEOUT_CYCLES  = RANDOM_CYCLES + DIRECTED_CYCLES + 100;

    logic              clk;
    logic              rst;
    dest_array_t       dest_port;
    vc_req_array_t     ovc_request;
    ivc_vec_t          ivc_request;
    ivc_vec_t          ovc_is_assigned;
    ivc_vec_t          assigned_ovc_not_full;
    vc_req_array_t     granted_ovc;
    ivc_vec_t          ovc_allocated;
    ivc_vec_t          ivc_vc_granted;
    ivc_vec_t          ivc_sw_granted;
    port_grant_array_t granted_dest_port;
    port_vec_t         any_sw_granted;

    int          value_errors;
    int          rule_errors;
    int          cycle_count;
    logic [31:0] rng_state;
    string       test_name;
    ivc_vec_t    last_sw;  // grants seen in the previous cycle
    ivc_vec_t    last_vc;

    baseline_allocator baseline_allocator_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count <= TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // dest bit k of an input port, own port skipped
    function automatic int dest_to_port(input int in_port, input int k);
        return (k < in_port) ? k : k + 1;
    endfunction

    task automatic check_vc(input string what, input vc_req_array_t exp, input vc_req_array_t act);
        if (act !== exp) begin
            value_errors++;
            $display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_ivc(input string what, input ivc_vec_t exp, input ivc_vec_t act);
        if (act !== exp) begin
            value_errors++;
            $display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_ports(input string what, input port_grant_array_t exp,
                               input port_grant_array_t act);
        if (act !== exp) begin
            value_errors++;
            $display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flags(input string what, input port_vec_t exp, input port_vec_t act);
        if (act !== exp) begin
            value_errors++;
            $display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic clear_inputs();
        dest_port             = '0;
        ovc_request           = '0;
        ivc_request           = '0;
        ovc_is_assigned       = '0;
        assigned_ovc_not_full = '0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        rst = 1'b1;
        clear_inputs();
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    // a requester left waiting keeps its request untouched
    task automatic drive_random();
        logic [31:0] r;
        logic        pending;
        for (int i = 0; i < PV; i++) begin
            r = next_rand();
            pending = (ivc_request[i] && !last_sw[i]) || ((|ovc_request[i]) && !last_vc[i]);
            assigned_ovc_not_full[i] = r[0] | r[1];  // credit most of the time
            if (!pending) begin
                dest_port[i]       = port_sel_t'(1 << (r[7:2] % P_1));
                ivc_request[i]     = r[8];
                ovc_is_assigned[i] = r[9];
                ovc_request[i]     = '0;
                if (!r[9] && (r[8] || r[10])) begin
                    ovc_request[i] = vc_mask_t'(r[31:16]);
                    if (ovc_request[i] == '0) ovc_request[i] = vc_mask_t'(1 << (r[15:11] % V));
                end
            end
        end
    endtask

    task automatic check_rules();
        vc_req_array_t     vc_bad;
        ivc_vec_t          vc_or;
        ivc_vec_t          ovc_seen;
        ivc_vec_t          sw_legal;
        port_grant_array_t exp_dest;
        port_vec_t         exp_any;
        port_vec_t         out_seen;
        int                o;
        vc_bad   = '0;
        vc_or    = '0;
        ovc_seen = '0;
        sw_legal = '0;
        exp_dest = '0;
        exp_any  = '0;
        out_seen = '0;
        for (int i = 0; i < PV; i++) begin
            vc_bad[i] = granted_ovc[i] & ~ovc_request[i];
            vc_or[i]  = |granted_ovc[i];
            for (int k = 0; k < P_1; k++) begin
                for (int v = 0; v < V; v++) begin
                    o = dest_to_port(i / V, k) * V + v;
                    if (dest_port[i][k] && granted_ovc[i][v]) begin
                        if (ovc_seen[o]) begin
                            rule_errors++;
                            $display("%s: ovc %0d granted to more than one ivc", test_name, o);
                        end
                        ovc_seen[o] = 1'b1;
                    end
                end
            end
            // speculative ivcs need a vc grant in the same cycle
            sw_legal[i] = ivc_request[i] & (ovc_is_assigned[i] ? assigned_ovc_not_full[i]
                                                                : ivc_vc_granted[i]);
            if (ivc_sw_granted[i]) begin
                if (exp_any[i / V]) begin
                    rule_errors++;
                    $display("%s: input port %0d got two switch grants", test_name, i / V);
                end
                exp_any[i / V]  = 1'b1;
                exp_dest[i / V] = dest_port[i];
            end
        end
        for (int p = 0; p < P; p++) begin
            for (int k = 0; k < P_1; k++) begin
                if (granted_dest_port[p][k]) begin
                    if (out_seen[dest_to_port(p, k)]) begin
                        rule_errors++;
                        $display("%s: output port %0d granted to two inputs", test_name,
                                 dest_to_port(p, k));
                    end
                    out_seen[dest_to_port(p, k)] = 1'b1;
                end
            end
        end
        check_vc("vc_subset", '0, vc_bad);
        check_ivc("ivc_vc_granted", vc_or, ivc_vc_granted);
        check_ivc("ovc_allocated", ovc_seen, ovc_allocated);
        check_ivc("sw_illegal", '0, ivc_sw_granted & ~sw_legal);
        check_ports("granted_dest_port", exp_dest, granted_dest_port);
        check_flags("any_sw_granted", exp_any, any_sw_granted);
    endtask

    initial begin
        vc_req_array_t     exp_vc;
        ivc_vec_t          exp_ivc;
        port_grant_array_t exp_ports;
        port_vec_t         exp_flags;
        rst          = 1'b1;
        clear_inputs();
        value_errors = 0;
        rule_errors  = 0;
        rng_state    = 32'd4876;
        last_sw      = '0;
        last_vc      = '0;

        // ivc 0 alone, top vc at dest bit 1
        test_name = "lone_request";
        apply_reset();
        dest_port[0]             = port_sel_t'(2);
        ovc_request[0]           = vc_mask_t'(1 << (V - 1));
        ivc_request[0]           = 1'b1;
        ovc_is_assigned[0]       = 1'b1;
        assigned_ovc_not_full[0] = 1'b1;
        @(negedge clk);
        exp_vc    = '0;
        exp_vc[0] = vc_mask_t'(1 << (V - 1));
        check_vc("granted_ovc", exp_vc, granted_ovc);
        exp_ivc    = '0;
        exp_ivc[0] = 1'b1;
        check_ivc("ivc_vc_granted", exp_ivc, ivc_vc_granted);
        check_ivc("ivc_sw_granted", exp_ivc, ivc_sw_granted);
        exp_ivc = '0;
        exp_ivc[dest_to_port(0, 1) * V + V - 1] = 1'b1;
        check_ivc("ovc_allocated", exp_ivc, ovc_allocated);
        exp_ports    = '0;
        exp_ports[0] = port_sel_t'(2);
        check_ports("granted_dest_port", exp_ports, granted_dest_port);
        exp_flags    = '0;
        exp_flags[0] = 1'b1;
        check_flags("any_sw_granted", exp_flags, any_sw_granted);

        // ivcs 2 and 4 both want ovc 0
        test_name = "round_robin";
        apply_reset();
        dest_port[2]   = port_sel_t'(1);
        dest_port[4]   = port_sel_t'(1);
        ovc_request[2] = vc_mask_t'(1);
        ovc_request[4] = vc_mask_t'(1);
        for (int c = 0; c < 6; c++) begin
            @(negedge clk);
            exp_vc = '0;
            if (c % 2 == 0) exp_vc[2] = vc_mask_t'(1);
            else exp_vc[4] = vc_mask_t'(1);
            check_vc("granted_ovc", exp_vc, granted_ovc);
        end

        // ivc 2 holds an ovc, ivc 4 speculates, both to port 0
        test_name = "nonspec_priority";
        apply_reset();
        dest_port             = '0;
        dest_port[2]          = port_sel_t'(1);
        dest_port[4]          = port_sel_t'(1);
        ivc_request[2]        = 1'b1;
        ivc_request[4]        = 1'b1;
        ovc_is_assigned[2]    = 1'b1;
        assigned_ovc_not_full = '1;
        ovc_request[4]        = vc_mask_t'(1);
        repeat (4) begin
            @(negedge clk);
            exp_ivc    = '0;
            exp_ivc[2] = 1'b1;
            check_ivc("ivc_sw_granted", exp_ivc, ivc_sw_granted);
            exp_ivc    = '0;
            exp_ivc[4] = 1'b1;
            check_ivc("ivc_vc_granted", exp_ivc, ivc_vc_granted);
            exp_ports    = '0;
            exp_ports[1] = port_sel_t'(1);
            check_ports("granted_dest_port", exp_ports, granted_dest_port);
        end

        test_name = "random_traffic";
        apply_reset();
        repeat (RANDOM_CYCLES) begin
            drive_random();
            @(negedge clk);
            check_rules();
            last_sw = ivc_sw_granted;
            last_vc = ivc_vc_granted;
            @(posedge clk);
            #2;
        end

        $display("summary: %0d value errors, %0d rule errors", value_errors, rule_errors);
        if (value_errors + rule_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+logic
logic/alloc_pkg.sv
logic/rr_arbiter.sv
logic/vc_allocator.sv
logic/sw_alloc_stage.sv
logic/spec_sw_allocator.sv
logic/baseline_allocator.sv
dv/baseline_allocator_chk.sv
dv/baseline_allocator_tb.sv

// File: Bender.yml
package:
  name: baseline_allocator

sources:
  - include_dirs:
      - logic
    files:
      - logic/alloc_pkg.sv
      - logic/rr_arbiter.sv
      - logic/vc_allocator.sv
      - logic/sw_alloc_stage.sv
      - logic/spec_sw_allocator.sv
      - logic/baseline_allocator.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/baseline_allocator_chk.sv
      - dv/baseline_allocator_tb.sv
